// ==== filelist.f ====
+incdir+source
source/cp0_pkg.sv
source/exception_unit.sv
source/cp0_regs.sv
source/redirect_ctrl.sv
source/exception_subsystem.sv
sim/tb_exception_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module tb_exception_subsystem \
    -Mdir obj_dir -o sim_tb &&
./obj_dir/sim_tb | grep "Regression passed" &&
echo "simulation ok" || { echo "simulation failed"; exit 1; }

// ==== sim/exception_trace.txt ====
# pc ds vaddr flags(instr ri ov sys bp load store) eret we addr wdata int_lines
# expected: redirect target status cause epc badvaddr
00400000 0 00000000 00 0 1 0c 1234ff05 00 0 00000000 0000ff05 00000000 00000000 00000000
00400004 0 00000000 00 0 1 08 deadbeef 00 0 00000000 0000ff05 00000000 00000000 00000000
00400008 0 00000000 00 0 1 0e 80001000 00 0 00000000 0000ff05 00000000 80001000 00000000
00400100 0 00000000 20 0 0 00 00000000 00 1 bfc00380 0000ff07 00000028 00400100 00000000
00400200 0 00000000 00 1 0 00 00000000 00 1 00400100 0000ff03 00000028 00400100 00000000
00400300 0 00000000 10 0 1 0e 11111111 00 1 bfc00380 0000ff03 00000030 00400100 00000000
00400304 0 00000000 00 1 0 00 00000000 00 1 00400100 0000ff01 00000030 00400100 00000000
00400400 0 00000000 08 0 0 00 00000000 00 1 bfc00380 0000ff03 00000020 00400400 00000000
00400404 0 00000000 00 1 0 00 00000000 00 1 00400400 0000ff01 00000020 00400400 00000000
00400500 0 00000000 04 0 0 00 00000000 00 1 bfc00380 0000ff03 00000024 00400500 00000000
00400504 0 00000000 00 1 0 00 00000000 00 1 00400500 0000ff01 00000024 00400500 00000000
00400600 0 12345679 1d 0 0 00 00000000 00 1 bfc00380 0000ff03 00000030 00400600 00000000
00400604 0 00000000 00 1 0 00 00000000 00 1 00400600 0000ff01 00000030 00400600 00000000
00400703 1 dead0000 40 0 0 00 00000000 00 1 bfc00380 0000ff03 80000010 004006ff 00400703
00400708 0 00000000 00 1 0 00 00000000 00 1 004006ff 0000ff01 80000010 004006ff 00400703
00400800 0 10000002 01 0 0 00 00000000 00 1 bfc00380 0000ff03 00000014 00400800 10000002
00400900 0 20000001 03 0 0 00 00000000 00 1 bfc00380 0000ff03 00000010 00400800 20000001
00400904 0 00000000 00 1 0 00 00000000 00 1 00400800 0000ff01 00000010 00400800 20000001
00400a00 0 00000000 20 0 0 00 00000000 01 1 bfc00380 0000ff03 00000400 00400a00 20000001
00400a04 0 00000000 00 1 0 00 00000000 00 1 00400a00 0000ff01 00000000 00400a00 20000001
00400b00 0 00000000 00 0 1 0c 00000001 00 0 00000000 00000001 00000000 00400a00 20000001
00400b04 0 00000000 00 0 0 00 00000000 3f 0 00000000 00000001 0000fc00 00400a00 20000001
00400b08 0 00000000 00 0 1 0c 0000ff00 3f 0 00000000 0000ff00 0000fc00 00400a00 20000001
00400b0c 0 00000000 00 0 0 00 00000000 3f 0 00000000 0000ff00 0000fc00 00400a00 20000001
00400b10 0 00000000 00 0 1 0c 0000ff01 00 0 00000000 0000ff01 00000000 00400a00 20000001
00400c00 1 00000000 0c 0 0 00 00000000 20 1 bfc00380 0000ff03 80008000 00400bfc 20000001
00400c04 0 00000000 00 1 0 00 00000000 00 1 00400bfc 0000ff01 80000000 00400bfc 20000001

// ==== sim/tb_exception_subsystem.sv ====
`timescale 1ns/10ps
`include "cp0_macros.svh"

module tb_exception_subsystem;

    localparam int max_lines = 64;
    localparam int num_cols  = 15;

    logic                  clk;
    logic                  rst_n;
    logic                  ret_valid;
    logic                  ret_ready;
    logic [`WORD_W-1:0]    ret_pc;
    logic                  ret_in_delay_slot;
    logic [`WORD_W-1:0]    ret_vaddr;
    logic                  exc_instr;
    logic                  exc_ri;
    logic                  exc_ov;
    logic                  exc_sys;
    logic                  exc_bp;
    logic                  exc_load;
    logic                  exc_store;
    logic                  ret_eret;
    logic                  ret_cp0_we;
    logic [4:0]            ret_cp0_addr;
    logic [`WORD_W-1:0]    ret_cp0_wdata;
    logic [5:0]            int_lines;
    logic [4:0]            cp0_raddr;
    logic [`WORD_W-1:0]    cp0_rdata;
    logic                  redirect_valid;
    logic [`WORD_W-1:0]    redirect_pc;
    logic                  flush;

    // one row per trace line, columns as in the trace file
    logic [`WORD_W-1:0]    trace_mem [0:max_lines-1][0:num_cols-1];
    logic [`WORD_W-1:0]    fields [0:num_cols-1];
    int                    n_lines;
    bit                    trace_loaded;

    exception_subsystem u_exception_subsystem (.*);

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got %h expected %h", name, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic load_trace();
        int fd;
        int count;
        int k;
        string line;
        fd = $fopen("sim/exception_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/exception_trace.txt");
            $display("Regression failed");
            $fatal(1, "missing trace");
        end else begin
            n_lines = 0;
            while (!$feof(fd) && n_lines < max_lines) begin
                line = "";
                void'($fgets(line, fd));
                // comment and blank lines do not scan to a full row
                count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                fields[0], fields[1], fields[2], fields[3], fields[4],
                                fields[5], fields[6], fields[7], fields[8], fields[9],
                                fields[10], fields[11], fields[12], fields[13], fields[14]);
                if (count == num_cols) begin
                    for (k = 0; k < num_cols; k++) begin
                        trace_mem[n_lines][k] = fields[k];
                    end
                    n_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_record(input int idx);
        ret_pc            = trace_mem[idx][0];
        ret_in_delay_slot = trace_mem[idx][1][0];
        ret_vaddr         = trace_mem[idx][2];
        {exc_instr, exc_ri, exc_ov, exc_sys, exc_bp, exc_load, exc_store} =
            trace_mem[idx][3][6:0];
        ret_eret          = trace_mem[idx][4][0];
        ret_cp0_we        = trace_mem[idx][5][0];
        ret_cp0_addr      = trace_mem[idx][6][4:0];
        ret_cp0_wdata     = trace_mem[idx][7];
        ret_valid         = 1'b1;
    endtask

    task automatic read_cp0(input logic [4:0] addr, output logic [31:0] data);
        cp0_raddr = addr;
        #1;
        data = cp0_rdata;
    endtask

    initial begin
        int gap;
        int i;
        logic [`WORD_W-1:0] rd;
        clk = 1'b0;
        rst_n = 1'b0;
        ret_valid = 1'b0;
        ret_pc = '0;
        int_lines = '0;
        cp0_raddr = '0;
        trace_loaded = 1'b0;
        void'($urandom(32'hc903f98b));
        {exc_instr, exc_ri, exc_ov, exc_sys, exc_bp, exc_load, exc_store} = '0;
        {ret_in_delay_slot, ret_eret, ret_cp0_we} = '0;
        {ret_vaddr, ret_cp0_addr, ret_cp0_wdata} = '0;
        load_trace();
        if (n_lines == 0) begin
            $display("trace file holds no records");
            $display("Regression failed");
            $fatal(1, "empty trace");
        end
        trace_loaded = 1'b1;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // status comes out of reset with only ERL set
        read_cp0(cp0_pkg::cp0_status, rd);
        check_value("status", rd, 32'h0000_0004);
        check_value("ret_ready", 32'(ret_ready), 32'd1);

        for (i = 0; i < n_lines; i++) begin
            @(negedge clk);
            ret_valid = 1'b0;
            // the redirect bubble lasts a single cycle
            check_value("ret_ready", 32'(ret_ready), 32'd1);
            check_value("redirect_valid", 32'(redirect_valid), 32'd0);
            check_value("flush", 32'(flush), 32'd0);
            int_lines = trace_mem[i][8][5:0];
            // int_lines needs one edge to reach cause IP
            gap = 1 + int'($urandom % 3);
            repeat (gap) @(negedge clk);
            drive_record(i);
            while (!ret_ready) @(negedge clk);
            @(posedge clk);
            @(negedge clk);
            ret_valid = 1'b0;
            check_value("redirect_valid", 32'(redirect_valid), trace_mem[i][9]);
            check_value("flush", 32'(flush), trace_mem[i][9]);
            check_value("ret_ready", 32'(ret_ready), 32'(!trace_mem[i][9][0]));
            if (trace_mem[i][9][0]) begin
                check_value("redirect_pc", redirect_pc, trace_mem[i][10]);
            end
            read_cp0(cp0_pkg::cp0_status, rd);
            check_value("status", rd, trace_mem[i][11]);
            read_cp0(cp0_pkg::cp0_cause, rd);
            check_value("cause", rd, trace_mem[i][12]);
            read_cp0(cp0_pkg::cp0_epc, rd);
            check_value("epc", rd, trace_mem[i][13]);
            read_cp0(cp0_pkg::cp0_badvaddr, rd);
            check_value("badvaddr", rd, trace_mem[i][14]);
        end

        $display("Regression passed");
        $finish;
    end

    // watchdog, 12 cycles per record plus reset
    initial begin
        int limit;
        wait (trace_loaded);
        limit = n_lines * 12 + 8 + 4;
        repeat (limit) @(posedge clk);
        $display("watchdog expired, the run hung waiting on the DUT");
        $display("Regression failed");
        $fatal(1, "timeout");
    end

endmodule

// ==== source/cp0_macros.svh ====
`ifndef CP0_MACROS_SVH
`define CP0_MACROS_SVH

// datapath and address width
`define WORD_W 32

// fixed exception vector, no BEV or TLB offsets
`define EXC_ENTRY 32'hbfc00380

// status bits
`define STATUS_IE 0
`define STATUS_EXL 1
`define STATUS_ERL 2
`define STATUS_IM_LO 8
`define STATUS_IM_HI 15

// cause bits
`define CAUSE_EXC_LO 2
`define CAUSE_EXC_HI 6
`define CAUSE_IP_LO 8
`define CAUSE_IP_HI 15
`define CAUSE_BD 31

`endif

// ==== source/cp0_pkg.sv ====
package cp0_pkg;

    // MIPS32 ExcCode values handled by this block
    // TLB and watch codes are not produced here
    typedef enum logic [4:0] {
        // hardware or software interrupt
        code_int  = 5'd0,
        // address error on load or instruction fetch
        code_adel = 5'd4,
        // address error on store
        code_ades = 5'd5,
        // syscall instruction
        code_sys  = 5'd8,
        // break instruction
        code_bp   = 5'd9,
        // reserved instruction
        code_ri   = 5'd10,
        // integer overflow
        code_ov   = 5'd12
    } exc_code_e;

    // coprocessor-0 register numbers, select 0 only
    typedef enum logic [4:0] {
        // last faulting virtual address, read-only
        cp0_badvaddr = 5'd8,
        // interrupt mask, EXL, ERL and IE
        cp0_status   = 5'd12,
        // BD, pending interrupts and ExcCode
        cp0_cause    = 5'd13,
        // exception return address
        cp0_epc      = 5'd14
    } cp0_addr_e;

endpackage

// ==== source/cp0_regs.sv ====
`timescale 1ns/10ps
`include "cp0_macros.svh"

module cp0_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ret_fire,
    input  logic                  exc_taken,
    input  cp0_pkg::exc_code_e    exc_code,
    input  logic                  ret_eret,
    input  logic [`WORD_W-1:0]    ret_pc,
    input  logic                  ret_in_delay_slot,
    input  logic [`WORD_W-1:0]    ret_vaddr,
    input  logic                  exc_instr,
    input  logic                  ret_cp0_we,
    input  logic [4:0]            ret_cp0_addr,
    input  logic [`WORD_W-1:0]    ret_cp0_wdata,
    input  logic [5:0]            int_lines,
    input  logic [4:0]            cp0_raddr,
    output logic [`WORD_W-1:0]    status,
    output logic [7:0]            cause_ip,
    output logic [`WORD_W-1:0]    epc,
    output logic [`WORD_W-1:0]    cp0_rdata
);

    // IM, ERL, EXL and IE are the only software-visible status bits
    localparam logic [`WORD_W-1:0] status_wmask = (`WORD_W'(8'hff) << `STATUS_IM_LO)
                                                | (`WORD_W'(1) << `STATUS_ERL)
                                                | (`WORD_W'(1) << `STATUS_EXL)
                                                | (`WORD_W'(1) << `STATUS_IE);

    logic                  cause_bd;
    logic [5:0]            ip_hw;
    logic [1:0]            ip_sw;
    cp0_pkg::exc_code_e    cause_exc;
    logic [`WORD_W-1:0]    badvaddr;
    logic [`WORD_W-1:0]    cause;
    logic                  take_exc;
    logic                  take_eret;
    logic                  take_write;

    assign take_exc   = ret_fire & exc_taken;
    assign take_eret  = ret_fire & ret_eret & ~exc_taken;
    assign take_write = ret_fire & ret_cp0_we & ~exc_taken;

    assign cause_ip = {ip_hw, ip_sw};

    always_comb begin
        cause = '0;
        cause[`CAUSE_BD] = cause_bd;
        cause[`CAUSE_IP_HI:`CAUSE_IP_LO] = cause_ip;
        cause[`CAUSE_EXC_HI:`CAUSE_EXC_LO] = cause_exc;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status <= '0;
            status[`STATUS_ERL] <= 1'b1;
            cause_bd <= 1'b0;
            ip_hw <= '0;
            ip_sw <= '0;
            cause_exc <= cp0_pkg::code_int;
            epc <= '0;
            badvaddr <= '0;
        end else begin
            // hardware lines sampled every cycle
            ip_hw <= int_lines;
            if (take_exc) begin
                status[`STATUS_EXL] <= 1'b1;
                cause_exc <= exc_code;
                // nested exception keeps the original return point
                if (!status[`STATUS_EXL]) begin
                    cause_bd <= ret_in_delay_slot;
                    epc <= ret_in_delay_slot ? ret_pc - `WORD_W'(4) : ret_pc;
                end
                if (exc_code == cp0_pkg::code_adel || exc_code == cp0_pkg::code_ades) begin
                    badvaddr <= exc_instr ? ret_pc : ret_vaddr;
                end
            end else if (take_eret) begin
                // ERL has precedence over EXL
                if (status[`STATUS_ERL]) begin
                    status[`STATUS_ERL] <= 1'b0;
                end else begin
                    status[`STATUS_EXL] <= 1'b0;
                end
            end else if (take_write) begin
                case (ret_cp0_addr)
                    cp0_pkg::cp0_status: status <= ret_cp0_wdata & status_wmask;
                    cp0_pkg::cp0_cause:  ip_sw <= ret_cp0_wdata[`CAUSE_IP_LO+1:`CAUSE_IP_LO];
                    cp0_pkg::cp0_epc:    epc <= ret_cp0_wdata;
                    // badvaddr is read-only
                    default: ;
                endcase
            end
        end
    end

    // read port shows state after the last edge
    always_comb begin
        case (cp0_raddr)
            cp0_pkg::cp0_badvaddr: cp0_rdata = badvaddr;
            cp0_pkg::cp0_status:   cp0_rdata = status;
            cp0_pkg::cp0_cause:    cp0_rdata = cause;
            cp0_pkg::cp0_epc:      cp0_rdata = epc;
            default:               cp0_rdata = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        ret_fire && exc_taken |=> status[`STATUS_EXL])
        else $error("cp0_regs: EXL not set after exception");

endmodule

// ==== source/exception_subsystem.sv ====
`timescale 1ns/10ps
`include "cp0_macros.svh"

module exception_subsystem (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ret_valid,
    output logic                  ret_ready,
    input  logic [`WORD_W-1:0]    ret_pc,
    input  logic                  ret_in_delay_slot,
    input  logic [`WORD_W-1:0]    ret_vaddr,
    input  logic                  exc_instr,
    input  logic                  exc_ri,
    input  logic                  exc_ov,
    input  logic                  exc_sys,
    input  logic                  exc_bp,
    input  logic                  exc_load,
    input  logic                  exc_store,
    input  logic                  ret_eret,
    input  logic                  ret_cp0_we,
    input  logic [4:0]            ret_cp0_addr,
    input  logic [`WORD_W-1:0]    ret_cp0_wdata,
    input  logic [5:0]            int_lines,
    input  logic [4:0]            cp0_raddr,
    output logic [`WORD_W-1:0]    cp0_rdata,
    output logic                  redirect_valid,
    output logic [`WORD_W-1:0]    redirect_pc,
    output logic                  flush
);

    logic                  exc_taken;
    cp0_pkg::exc_code_e    exc_code;
    logic [`WORD_W-1:0]    status;
    logic [7:0]            cause_ip;
    logic [`WORD_W-1:0]    epc;
    logic                  ret_fire;

    exception_unit u_exception_unit (
        .ret_valid (ret_valid),
        .ret_eret  (ret_eret),
        .exc_instr (exc_instr),
        .exc_ri    (exc_ri),
        .exc_ov    (exc_ov),
        .exc_sys   (exc_sys),
        .exc_bp    (exc_bp),
        .exc_load  (exc_load),
        .exc_store (exc_store),
        .status    (status),
        .cause_ip  (cause_ip),
        .exc_taken (exc_taken),
        .exc_code  (exc_code)
    );

    cp0_regs u_cp0_regs (
        .clk               (clk),
        .rst_n             (rst_n),
        .ret_fire          (ret_fire),
        .exc_taken         (exc_taken),
        .exc_code          (exc_code),
        .ret_eret          (ret_eret),
        .ret_pc            (ret_pc),
        .ret_in_delay_slot (ret_in_delay_slot),
        .ret_vaddr         (ret_vaddr),
        .exc_instr         (exc_instr),
        .ret_cp0_we        (ret_cp0_we),
        .ret_cp0_addr      (ret_cp0_addr),
        .ret_cp0_wdata     (ret_cp0_wdata),
        .int_lines         (int_lines),
        .cp0_raddr         (cp0_raddr),
        .status            (status),
        .cause_ip          (cause_ip),
        .epc               (epc),
        .cp0_rdata         (cp0_rdata)
    );

    redirect_ctrl u_redirect_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .ret_valid      (ret_valid),
        .exc_taken      (exc_taken),
        .ret_eret       (ret_eret),
        .epc            (epc),
        .ret_ready      (ret_ready),
        .ret_fire       (ret_fire),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush          (flush)
    );

endmodule

// ==== source/exception_unit.sv ====
`timescale 1ns/10ps
`include "cp0_macros.svh"

module exception_unit (
    input  logic                  ret_valid,
    input  logic                  ret_eret,
    input  logic                  exc_instr,
    input  logic                  exc_ri,
    input  logic                  exc_ov,
    input  logic                  exc_sys,
    input  logic                  exc_bp,
    input  logic                  exc_load,
    input  logic                  exc_store,
    input  logic [`WORD_W-1:0]    status,
    input  logic [7:0]            cause_ip,
    output logic                  exc_taken,
    output cp0_pkg::exc_code_e    exc_code
);

    logic [7:0] int_pending;
    logic       int_valid;
    logic       found;

    // pending and unmasked lines
    assign int_pending = cause_ip & status[`STATUS_IM_HI:`STATUS_IM_LO];

    // interrupts are blocked inside a handler or after reset
    assign int_valid = (|int_pending)
                     & status[`STATUS_IE]
                     & ~status[`STATUS_EXL]
                     & ~status[`STATUS_ERL];

    always_comb begin
        found    = 1'b1;
        exc_code = cp0_pkg::code_int;
        if (int_valid) begin
            exc_code = cp0_pkg::code_int;
        end else if (exc_instr) begin
            exc_code = cp0_pkg::code_adel;
        end else if (exc_ri) begin
            exc_code = cp0_pkg::code_ri;
        end else if (exc_ov) begin
            exc_code = cp0_pkg::code_ov;
        end else if (exc_sys) begin
            exc_code = cp0_pkg::code_sys;
        end else if (exc_bp) begin
            exc_code = cp0_pkg::code_bp;
        end else if (exc_load) begin
            exc_code = cp0_pkg::code_adel;
        end else if (exc_store) begin
            exc_code = cp0_pkg::code_ades;
        end else begin
            found = 1'b0;
        end

        // only a presented record can take anything
        exc_taken = ret_valid & found;

        if (exc_taken) begin
            assert (exc_code inside {cp0_pkg::code_int, cp0_pkg::code_adel,
                                     cp0_pkg::code_ades, cp0_pkg::code_sys,
                                     cp0_pkg::code_bp, cp0_pkg::code_ri,
                                     cp0_pkg::code_ov})
                else $error("exception_unit: illegal exc_code %0d", exc_code);
        end
        assert (ret_valid || !exc_taken)
            else $error("exception_unit: exc_taken without ret_valid");
    end

endmodule

// ==== source/redirect_ctrl.sv ====
`timescale 1ns/10ps
`include "cp0_macros.svh"

module redirect_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ret_valid,
    input  logic                  exc_taken,
    input  logic                  ret_eret,
    input  logic [`WORD_W-1:0]    epc,
    output logic                  ret_ready,
    output logic                  ret_fire,
    output logic                  redirect_valid,
    output logic [`WORD_W-1:0]    redirect_pc,
    output logic                  flush
);

    logic ret_event;
    logic event_q;

    assign ret_fire = ret_valid & ret_ready;

    // exception or eret on an accepted record
    assign ret_event = ret_fire & (exc_taken | ret_eret);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            event_q <= 1'b0;
        end else begin
            event_q <= ret_event;
        end
    end

    // target captured with the event, exception wins over eret
    always_ff @(posedge clk) begin
        if (ret_event) begin
            redirect_pc <= exc_taken ? `EXC_ENTRY : epc;
        end
    end

    assign redirect_valid = event_q;
    assign flush          = event_q;

    // one bubble while fetch turns around
    assign ret_ready = ~event_q;

    assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |=> !redirect_valid)
        else $error("redirect_ctrl: redirect held for two cycles");

endmodule
